/* verilog/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

  localparam int XLEN = 32;

  // Major opcode, instruction bits 6:2
  typedef enum logic [4:0] {
    OPCODE_LOAD     = 5'b00000,
    OPCODE_MISC_MEM = 5'b00011,
    OPCODE_OP_IMM   = 5'b00100,
    OPCODE_AUIPC    = 5'b00101,
    OPCODE_STORE    = 5'b01000,
    OPCODE_OP       = 5'b01100,
    OPCODE_LUI      = 5'b01101,
    OPCODE_BRANCH   = 5'b11000,
    OPCODE_JALR     = 5'b11001,
    OPCODE_JAL      = 5'b11011,
    OPCODE_SYSTEM   = 5'b11100
  } opcode_t;

  // Bits 1:0 of every 32-bit encoding
  localparam logic [1:0] INST_LOW_32 = 2'b11;

  // Arithmetic funct3
  localparam logic [2:0] FUNCT3_ADD  = 3'b000;
  localparam logic [2:0] FUNCT3_SLL  = 3'b001;
  localparam logic [2:0] FUNCT3_SLT  = 3'b010;
  localparam logic [2:0] FUNCT3_SLTU = 3'b011;
  localparam logic [2:0] FUNCT3_XOR  = 3'b100;
  localparam logic [2:0] FUNCT3_SR   = 3'b101;
  localparam logic [2:0] FUNCT3_OR   = 3'b110;
  localparam logic [2:0] FUNCT3_AND  = 3'b111;

  // Branch funct3
  localparam logic [2:0] FUNCT3_BEQ  = 3'b000;
  localparam logic [2:0] FUNCT3_BNE  = 3'b001;
  localparam logic [2:0] FUNCT3_BLT  = 3'b100;
  localparam logic [2:0] FUNCT3_BGE  = 3'b101;
  localparam logic [2:0] FUNCT3_BLTU = 3'b110;
  localparam logic [2:0] FUNCT3_BGEU = 3'b111;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_t    opcode;
    logic [1:0] quadrant;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_t     opcode;
    logic [1:0]  quadrant;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    opcode_t    opcode;
    logic [1:0] quadrant;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    opcode_t    opcode;
    logic [1:0] quadrant;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    opcode_t     opcode;
    logic [1:0]  quadrant;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    opcode_t    opcode;
    logic [1:0] quadrant;
  } j_fmt_t;

  // Same word, read per format
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } rv_inst_t;

endpackage

`default_nettype wire

/* verilog/exec_pipe_pkg.sv */
`default_nettype none

package exec_pipe_pkg;

  import rv_isa_pkg::*;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    rv_inst_t        inst;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
  } issue_t;

  // Stage 1 output
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    rv_inst_t        inst;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [4:0]      rd_addr;
    logic            rd_wb;
    logic            illegal;
  } decoded_op_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] data;
  } alu_result_t;

  // Also carries the destination fields to stage 3
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] npc;
    logic [XLEN-1:0] link;
    logic            is_jump;
    logic [4:0]      rd_addr;
    logic            rd_wb;
    logic            illegal;
  } flow_result_t;

  typedef struct packed {
    logic            valid;
    logic            rd_wb;
    logic [4:0]      rd_addr;
    logic [XLEN-1:0] rd_data;
    logic [XLEN-1:0] npc;
    logic            illegal;
  } retire_t;

endpackage

`default_nettype wire

/* verilog/inst_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_decoder
  import rv_isa_pkg::*;
  import exec_pipe_pkg::*;
(
  input  wire         clk,
  input  wire         nrst,
  input  wire issue_t i_issue,
  output decoded_op_t o_op
);

  rv_inst_t        inst;
  opcode_t         opcode;
  logic [XLEN-1:0] imm;
  logic            illegal;
  logic            writes_rd;
  decoded_op_t     op_d;

  assign inst   = i_issue.inst;
  assign opcode = inst.r_fmt.opcode;

  // Immediate by format
  always_comb begin
    case (opcode)
      OPCODE_STORE: begin
        imm = {{20{inst.s_fmt.imm_11_5[6]}}, inst.s_fmt.imm_11_5, inst.s_fmt.imm_4_0};
      end
      OPCODE_LUI, OPCODE_AUIPC: begin
        imm = {inst.u_fmt.imm_31_12, 12'h000};
      end
      OPCODE_JAL: begin
        imm = {{12{inst.j_fmt.imm_20}}, inst.j_fmt.imm_19_12, inst.j_fmt.imm_11,
               inst.j_fmt.imm_10_1, 1'b0};
      end
      OPCODE_BRANCH: begin
        imm = {{20{inst.b_fmt.imm_12}}, inst.b_fmt.imm_11, inst.b_fmt.imm_10_5,
               inst.b_fmt.imm_4_1, 1'b0};
      end
      default: begin
        imm = {{20{inst.i_fmt.imm_11_0[11]}}, inst.i_fmt.imm_11_0};
      end
    endcase
  end

  // Memory, fence and system opcodes have no path here
  assign illegal = (inst.r_fmt.quadrant != INST_LOW_32) ||
                   !(opcode inside {OPCODE_OP, OPCODE_OP_IMM, OPCODE_LUI, OPCODE_AUIPC,
                                    OPCODE_JAL, OPCODE_JALR, OPCODE_BRANCH});

  assign writes_rd = (opcode inside {OPCODE_OP, OPCODE_OP_IMM, OPCODE_LUI, OPCODE_AUIPC,
                                     OPCODE_JAL, OPCODE_JALR}) &&
                     (inst.r_fmt.rd != 5'd0) && !illegal;

  always_comb begin
    op_d.valid    = i_issue.valid;
    op_d.pc       = i_issue.pc;
    op_d.inst     = inst;
    op_d.imm      = imm;
    op_d.rs1_data = i_issue.rs1_data;
    op_d.rs2_data = i_issue.rs2_data;
    op_d.rd_addr  = inst.r_fmt.rd;
    op_d.rd_wb    = writes_rd;
    op_d.illegal  = illegal;
  end

  always_ff @(posedge clk) begin
    o_op <= op_d;
    if (!nrst) begin
      o_op.valid <= 1'b0;
    end
  end

  // x0 is never written anywhere downstream
  a_no_x0_write : assert property (@(posedge clk) disable iff (!nrst)
    o_op.valid && o_op.rd_wb |-> o_op.rd_addr != 5'd0)
    else $error("decoded write-back to x0");

endmodule

`default_nettype wire

/* verilog/int_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module int_alu
  import rv_isa_pkg::*;
  import exec_pipe_pkg::*;
(
  input  wire              clk,
  input  wire              nrst,
  input  wire decoded_op_t i_op,
  output alu_result_t      o_alu
);

  opcode_t         opcode;
  logic [2:0]      funct3;
  logic [XLEN-1:0] src1;
  logic [XLEN-1:0] src2;
  logic [2:0]      operation;
  logic            alternate;
  logic [4:0]      shamt;
  logic [XLEN-1:0] result;
  alu_result_t     alu_d;

  assign opcode = i_op.inst.r_fmt.opcode;
  assign funct3 = i_op.inst.r_fmt.funct3;

  // Operand select
  always_comb begin
    if (opcode == OPCODE_LUI) begin
      src1 = '0;
    end else if (opcode inside {OPCODE_AUIPC, OPCODE_JAL}) begin
      src1 = i_op.pc;
    end else begin
      src1 = i_op.rs1_data;
    end
    if (opcode inside {OPCODE_OP_IMM, OPCODE_LUI, OPCODE_AUIPC, OPCODE_JAL, OPCODE_JALR}) begin
      src2 = i_op.imm;
    end else begin
      src2 = i_op.rs2_data;
    end
  end

  // Bit 30 selects SUB and SRA
  always_comb begin
    if (opcode inside {OPCODE_OP, OPCODE_OP_IMM}) begin
      operation = funct3;
    end else begin
      operation = FUNCT3_ADD;
    end
    if (opcode == OPCODE_OP) begin
      alternate = i_op.inst.r_fmt.funct7[5];
    end else if (opcode == OPCODE_OP_IMM && funct3 == FUNCT3_SR) begin
      alternate = i_op.inst.r_fmt.funct7[5];
    end else begin
      alternate = 1'b0;
    end
  end

  assign shamt = src2[4:0];

  always_comb begin
    case (operation)
      FUNCT3_ADD:  result = alternate ? src1 - src2 : src1 + src2;
      FUNCT3_SLL:  result = src1 << shamt;
      FUNCT3_SLT:  result = {31'd0, $signed(src1) < $signed(src2)};
      FUNCT3_SLTU: result = {31'd0, src1 < src2};
      FUNCT3_XOR:  result = src1 ^ src2;
      FUNCT3_SR:   result = alternate ? $unsigned($signed(src1) >>> shamt) : src1 >> shamt;
      FUNCT3_OR:   result = src1 | src2;
      default:     result = src1 & src2;
    endcase
  end

  assign alu_d.valid = i_op.valid;
  assign alu_d.data  = result;

  always_ff @(posedge clk) begin
    o_alu <= alu_d;
    if (!nrst) begin
      o_alu.valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* verilog/branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_unit
  import rv_isa_pkg::*;
  import exec_pipe_pkg::*;
(
  input  wire              clk,
  input  wire              nrst,
  input  wire decoded_op_t i_op,
  output flow_result_t     o_flow
);

  opcode_t         opcode;
  logic            is_eq;
  logic            is_lt;
  logic            is_ltu;
  logic            taken;
  logic [XLEN-1:0] link;
  logic [XLEN-1:0] jalr_target;
  flow_result_t    flow_d;

  assign opcode = i_op.inst.r_fmt.opcode;

  // Own comparator, independent of the ALU
  assign is_eq  = i_op.rs1_data == i_op.rs2_data;
  assign is_lt  = $signed(i_op.rs1_data) < $signed(i_op.rs2_data);
  assign is_ltu = i_op.rs1_data < i_op.rs2_data;

  always_comb begin
    case (i_op.inst.b_fmt.funct3)
      FUNCT3_BEQ:  taken = is_eq;
      FUNCT3_BNE:  taken = !is_eq;
      FUNCT3_BLT:  taken = is_lt;
      FUNCT3_BGE:  taken = !is_lt;
      FUNCT3_BLTU: taken = is_ltu;
      FUNCT3_BGEU: taken = !is_ltu;
      default:     taken = 1'b0;
    endcase
  end

  assign link        = i_op.pc + 32'd4;
  assign jalr_target = i_op.rs1_data + i_op.imm;

  always_comb begin
    flow_d.valid   = i_op.valid;
    flow_d.link    = link;
    flow_d.is_jump = !i_op.illegal && (opcode inside {OPCODE_JAL, OPCODE_JALR});
    flow_d.rd_addr = i_op.rd_addr;
    flow_d.rd_wb   = i_op.rd_wb;
    flow_d.illegal = i_op.illegal;
    if (i_op.illegal) begin
      flow_d.npc = link;
    end else if (opcode == OPCODE_JAL || (opcode == OPCODE_BRANCH && taken)) begin
      flow_d.npc = i_op.pc + i_op.imm;
    end else if (opcode == OPCODE_JALR) begin
      flow_d.npc = {jalr_target[XLEN-1:1], 1'b0};
    end else begin
      flow_d.npc = link;
    end
  end

  always_ff @(posedge clk) begin
    o_flow <= flow_d;
    if (!nrst) begin
      o_flow.valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* verilog/writeback_merge.sv */
`timescale 1ns/1ps
`default_nettype none

module writeback_merge
  import exec_pipe_pkg::*;
(
  input  wire               clk,
  input  wire               nrst,
  input  wire alu_result_t  i_alu,
  input  wire flow_result_t i_flow,
  output retire_t           o_retire
);

  retire_t retire_d;

  always_comb begin
    retire_d.valid   = i_alu.valid & i_flow.valid;
    retire_d.rd_wb   = i_flow.rd_wb;
    retire_d.rd_addr = i_flow.rd_addr;
    retire_d.npc     = i_flow.npc;
    retire_d.illegal = i_flow.illegal;
    // Jumps write the return address
    if (i_flow.is_jump) begin
      retire_d.rd_data = i_flow.link;
    end else begin
      retire_d.rd_data = i_alu.data;
    end
  end

  // Output is a one-cycle pulse, zero otherwise
  always_ff @(posedge clk) begin
    if (!nrst || !retire_d.valid) begin
      o_retire <= '0;
    end else begin
      o_retire <= retire_d;
    end
  end

  // Stage 2 paths advance together
  a_stage2_lockstep : assert property (@(posedge clk) disable iff (!nrst)
    i_alu.valid == i_flow.valid)
    else $error("ALU valid out of step with the flow path");

  a_illegal_no_wb : assert property (@(posedge clk) disable iff (!nrst)
    o_retire.valid && o_retire.illegal |-> !o_retire.rd_wb)
    else $error("illegal instruction retired with write-back");

endmodule

`default_nettype wire

/* verilog/exec_core.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_core
  import exec_pipe_pkg::*;
(
  input  wire         clk,
  input  wire         nrst,
  input  wire issue_t i_issue,
  output retire_t     o_retire
);

  decoded_op_t  s1_op;
  alu_result_t  s2_alu;
  flow_result_t s2_flow;

  inst_decoder u_inst_decoder (
    .clk     (clk),
    .nrst    (nrst),
    .i_issue (i_issue),
    .o_op    (s1_op)
  );

  // Stage 2 paths run side by side
  int_alu u_int_alu (
    .clk   (clk),
    .nrst  (nrst),
    .i_op  (s1_op),
    .o_alu (s2_alu)
  );

  branch_unit u_branch_unit (
    .clk    (clk),
    .nrst   (nrst),
    .i_op   (s1_op),
    .o_flow (s2_flow)
  );

  writeback_merge u_writeback_merge (
    .clk      (clk),
    .nrst     (nrst),
    .i_alu    (s2_alu),
    .i_flow   (s2_flow),
    .o_retire (o_retire)
  );

endmodule

`default_nettype wire

/* verification/exec_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_core_tb
  import exec_pipe_pkg::*;
();

  localparam int MAX_LINES = 64;
  localparam int LATENCY   = 3;
  localparam int ROUNDS    = 2;

  logic    clk;
  logic    nrst;
  issue_t  i_issue;
  retire_t o_retire;

  // Trace columns
  string       t_name    [MAX_LINES];
  logic [31:0] t_pc      [MAX_LINES];
  logic [31:0] t_inst    [MAX_LINES];
  logic [31:0] t_rs1     [MAX_LINES];
  logic [31:0] t_rs2     [MAX_LINES];
  logic        t_rd_wb   [MAX_LINES];
  logic [4:0]  t_rd_addr [MAX_LINES];
  logic [31:0] t_rd_data [MAX_LINES];
  logic [31:0] t_npc     [MAX_LINES];
  logic        t_illegal [MAX_LINES];
  int          num_lines;
  bit          trace_loaded;

  // Outstanding instructions, oldest first
  int pend_idx   [$];
  int pend_round [$];
  int pend_cycle [$];

  int cycle = 0;
  int tests_run;
  int tests_failed;
  int other_errors;

  exec_core dut (
    .clk      (clk),
    .nrst     (nrst),
    .i_issue  (i_issue),
    .o_retire (o_retire)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  task automatic load_trace();
    int          fd;
    int          code;
    int          fields;
    string       line;
    string       name;
    logic [31:0] pc;
    logic [31:0] inst;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic [31:0] wb;
    logic [31:0] rd;
    logic [31:0] data;
    logic [31:0] npc;
    logic [31:0] ill;
    num_lines = 0;
    fd = $fopen("verification/exec_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open verification/exec_trace.txt");
      other_errors++;
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code > 0 && line.getc(0) != "#") begin
          fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h",
                           name, pc, inst, rs1, rs2, wb, rd, data, npc, ill);
          if (fields == 10 && num_lines < MAX_LINES) begin
            t_name[num_lines]    = name;
            t_pc[num_lines]      = pc;
            t_inst[num_lines]    = inst;
            t_rs1[num_lines]     = rs1;
            t_rs2[num_lines]     = rs2;
            t_rd_wb[num_lines]   = wb[0];
            t_rd_addr[num_lines] = rd[4:0];
            t_rd_data[num_lines] = data;
            t_npc[num_lines]     = npc;
            t_illegal[num_lines] = ill[0];
            num_lines++;
          end else if (fields > 0) begin
            $display("Malformed trace line skipped: %s", line);
            other_errors++;
          end
        end
      end
      $fclose(fd);
    end
    if (num_lines == 0) begin
      $display("The trace holds no tests");
      other_errors++;
    end
  endtask

  task automatic issue_line(input int idx, input int round);
    @(negedge clk);
    i_issue.valid    = 1'b1;
    i_issue.pc       = t_pc[idx];
    i_issue.inst     = t_inst[idx];
    i_issue.rs1_data = t_rs1[idx];
    i_issue.rs2_data = t_rs2[idx];
    pend_idx.push_back(idx);
    pend_round.push_back(round);
    // Sampled at the next rising edge
    pend_cycle.push_back(cycle + 1);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge clk);
      i_issue = '0;
    end
  endtask

  task automatic wait_drain(input int max_cycles);
    int waited;
    waited = 0;
    while (pend_idx.size() != 0 && waited < max_cycles) begin
      @(negedge clk);
      waited++;
    end
    // Catch stray retires
    repeat (2) @(negedge clk);
  endtask

  task automatic show_mismatch(input string test, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
    $display("** Error: %s %s expected %0h actual %0h", test, field, expected, actual);
  endtask

  task automatic check_retire();
    int    idx;
    int    round;
    int    issued;
    int    latency;
    bit    ok;
    string name;
    if (pend_idx.size() == 0) begin
      $display("Retire at cycle %0d with no instruction outstanding", cycle);
      other_errors++;
    end else begin
      idx    = pend_idx.pop_front();
      round  = pend_round.pop_front();
      issued = pend_cycle.pop_front();
      name   = t_name[idx];
      ok     = 1'b1;
      // The retire is taken at the next rising edge, like the issue
      latency = cycle + 1 - issued;
      if (o_retire.illegal !== t_illegal[idx]) begin
        show_mismatch(name, "illegal", t_illegal[idx], o_retire.illegal);
        ok = 1'b0;
      end
      if (o_retire.rd_wb !== t_rd_wb[idx]) begin
        show_mismatch(name, "rd_wb", t_rd_wb[idx], o_retire.rd_wb);
        ok = 1'b0;
      end
      if (o_retire.npc !== t_npc[idx]) begin
        show_mismatch(name, "npc", t_npc[idx], o_retire.npc);
        ok = 1'b0;
      end
      if (latency != LATENCY) begin
        show_mismatch(name, "latency", LATENCY, latency);
        ok = 1'b0;
      end
      // Destination only matters when written
      if (t_rd_wb[idx]) begin
        if (o_retire.rd_addr !== t_rd_addr[idx]) begin
          show_mismatch(name, "rd_addr", t_rd_addr[idx], o_retire.rd_addr);
          ok = 1'b0;
        end
        if (o_retire.rd_data !== t_rd_data[idx]) begin
          show_mismatch(name, "rd_data", t_rd_data[idx], o_retire.rd_data);
          ok = 1'b0;
        end
      end
      tests_run++;
      if (ok) begin
        $display("ok    round %0d  %s", round, name);
      end else begin
        tests_failed++;
        $display("fail  round %0d  %s", round, name);
      end
    end
  endtask

  always @(negedge clk) begin
    if (nrst && o_retire.valid === 1'b1) begin
      check_retire();
    end
  end

  initial begin
    int gap;
    void'($urandom(32'he989_89fc));
    nrst         = 1'b0;
    i_issue      = '0;
    tests_run    = 0;
    tests_failed = 0;
    other_errors = 0;
    load_trace();
    trace_loaded = 1'b1;
    repeat (4) @(negedge clk);
    nrst = 1'b1;
    if (o_retire !== '0) begin
      $display("o_retire was not cleared by reset");
      other_errors++;
    end
    // Round 1 with random gaps, round 2 back to back
    for (int r = 1; r <= ROUNDS; r++) begin
      for (int i = 0; i < num_lines; i++) begin
        issue_line(i, r);
        gap = (r == 1) ? $urandom % 3 : 0;
        idle_cycles(gap);
      end
    end
    idle_cycles(1);
    wait_drain(LATENCY + 5);
    if (pend_idx.size() != 0) begin
      $display("%0d issued instructions never retired", pend_idx.size());
      other_errors++;
    end
    $display("Summary: %0d tests, %0d passed, %0d failed, %0d other errors",
             tests_run, tests_run - tests_failed, tests_failed, other_errors);
    if (tests_failed == 0 && other_errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // Two rounds of at most three cycles per line, plus reset and drain
  initial begin
    wait (trace_loaded);
    repeat (num_lines * 6 + 20) @(posedge clk);
    $display("Timeout: run did not finish within %0d cycles", num_lines * 6 + 20);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
verilog/rv_isa_pkg.sv
verilog/exec_pipe_pkg.sv
verilog/inst_decoder.sv
verilog/int_alu.sv
verilog/branch_unit.sv
verilog/writeback_merge.sv
verilog/exec_core.sv
verification/exec_core_tb.sv

/* verification/exec_trace.txt */
# name pc inst rs1_data rs2_data, then expected rd_wb rd_addr rd_data npc illegal (all hex)
# rd_addr and rd_data only count when rd_wb is 1
add        00001000 003100B3 80000F31 00000FE4 1 01 80001F15 00001004 0
sub        00001004 403100B3 80000F31 00000FE4 1 01 7FFFFF4D 00001008 0
sll        00001008 003110B3 80000F31 00000FE4 1 01 0000F310 0000100C 0
slt        0000100C 003120B3 80000F31 00000FE4 1 01 00000001 00001010 0
sltu       00001010 003130B3 80000F31 00000FE4 1 01 00000000 00001014 0
xor        00001014 003140B3 80000F31 00000FE4 1 01 800000D5 00001018 0
srl        00001018 003150B3 80000F31 00000FE4 1 01 080000F3 0000101C 0
sra        0000101C 403150B3 80000F31 00000FE4 1 01 F80000F3 00001020 0
or         00001020 003160B3 80000F31 00000FE4 1 01 80000FF5 00001024 0
and        00001024 003170B3 80000F31 00000FE4 1 01 00000F20 00001028 0
addi_neg   00001028 FFF10293 00000010 00000000 1 05 0000000F 0000102C 0
addi_b30   0000102C 40010293 00000010 00000000 1 05 00000410 00001030 0
sltiu      00001030 FFF13293 00000010 00000000 1 05 00000001 00001034 0
srai       00001038 40815293 80000000 00000000 1 05 FF800000 0000103C 0
xori       0000103C 7FF14293 12345678 00000000 1 05 12345187 00001040 0
lui        00001040 12345237 DEADBEEF 00000000 1 04 12345000 00001044 0
lui_x0     00001044 ABCDE037 00000000 00000000 0 00 00000000 00001048 0
auipc      00001048 FFFFF217 00000000 00000000 1 04 00000048 0000104C 0
beq_t      00002000 00310863 00000005 00000005 0 00 00000000 00002010 0
beq_nt     00002010 00310863 00000005 00000006 0 00 00000000 00002014 0
bne_t      00002020 FE311CE3 00000005 00000006 0 00 00000000 00002018 0
bne_nt     00002030 FE311CE3 00000007 00000007 0 00 00000000 00002034 0
blt_t      00002040 00314863 FFFFFFFF 00000001 0 00 00000000 00002050 0
blt_nt     00002050 00314863 00000001 FFFFFFFF 0 00 00000000 00002054 0
bge_t      00002060 00315863 00000001 FFFFFFFF 0 00 00000000 00002070 0
bge_nt     00002070 00315863 FFFFFFFF 00000001 0 00 00000000 00002074 0
bltu_t     00002080 00316863 00000001 FFFFFFFF 0 00 00000000 00002090 0
bltu_nt    00002090 00316863 FFFFFFFF 00000001 0 00 00000000 00002094 0
bgeu_t     000020A0 00317863 FFFFFFFF 00000001 0 00 00000000 000020B0 0
bgeu_nt    000020B0 00317863 00000001 FFFFFFFF 0 00 00000000 000020B4 0
jal        00003000 100000EF 00000000 00000000 1 01 00003004 00003100 0
jal_back   00003100 FFDFF2EF 00000000 00000000 1 05 00003104 000030FC 0
jalr       00003200 005100E7 00002000 00000000 1 01 00003204 00002004 0
jalr_x0    00003300 FFD10067 00003000 00000000 0 00 00000000 00002FFC 0
load       00004000 00012083 00000100 00000000 0 00 00000000 00004004 1
store      00004004 00312223 00000100 00000055 0 00 00000000 00004008 1
ecall      00004008 00000073 00000000 00000000 0 00 00000000 0000400C 1
bad_low    0000400C 003100B1 80000F31 00000FE4 0 00 00000000 00004010 1
